/* gray_afu.f */
gray_pkg.sv
gray_fifo.sv
gray_pixel_conv.sv
gray_requestor.sv
gray_afu.sv
gray_afu_sva.sv
gray_mem_model.sv
gray_afu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the grayscale accelerator testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module gray_afu_tb -f gray_afu.f -o sim_gray_afu

./obj_dir/sim_gray_afu +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
echo "Run passed"

/* gray_afu_tb.sv */
// Testbench top that runs two grayscale jobs against the memory model and checks every line
`timescale 1ns/100ps

module gray_afu_tb import gray_pkg::*; ();

  localparam int       FIFO_DEPTH      = 16;
  localparam int       MAX_OUTSTANDING = 8;  // Below the credit limit so both caps take turns
  localparam int       DONE_TIMEOUT    = 20000;
  localparam int       LOG_TIMEOUT     = 50;
  localparam cl_addr_t DSM_ADDR        = 32'h0000_8000;

  logic        clk;
  logic        reset;
  logic [31:0] hc_control;
  cl_addr_t    hc_dsm_base;
  buf_desc_t   src_buf;
  buf_desc_t   dst_buf;
  rd_req_t     rd_req;
  rd_rsp_t     rd_rsp;
  wr_req_t     wr_req;
  wr_rsp_t     wr_rsp;
  logic        rd_alm_full;
  logic        wr_alm_full;
  logic        done;
  int          errors;
  int          timeouts;
  logic        ok;

  gray_afu #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .src_buf     (src_buf),
    .dst_buf     (dst_buf),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .wr_req      (wr_req),
    .wr_rsp      (wr_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_alm_full (wr_alm_full),
    .done        (done)
  );

  gray_mem_model mem (
    .clk         (clk),
    .reset       (reset),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .wr_req      (wr_req),
    .wr_rsp      (wr_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_alm_full (wr_alm_full)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ##########################################################
  // Helpers
  // ##########################################################

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Gray is (77 R + 150 G + 29 B) / 256 in bytes 0 to 2, alpha stays in byte 3
  function automatic cl_data_t gray_line(input cl_data_t src);
    cl_data_t res;
    int       r;
    int       g;
    int       b;
    int       y;
    for (int p = 0; p < 16; p++) begin
      r = int'(src[32*p +: 8]);
      g = int'(src[32*p+8 +: 8]);
      b = int'(src[32*p+16 +: 8]);
      y = (77 * r + 150 * g + 29 * b) / 256;
      res[32*p +: 32] = {src[32*p+24 +: 8], y[7:0], y[7:0], y[7:0]};
    end
    return res;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
  endtask

  task automatic check_idle(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value({name, " idle outputs"}, '0, {rd_req.valid, wr_req.valid, done});
    end
  endtask

  // ##########################################################
  // One job from reset to completion
  // ##########################################################

  task automatic run_job(input string name, input int lines, input cl_addr_t src_base,
                         input cl_addr_t dst_base, output logic passed);
    int       cycles;
    int       off;
    cl_addr_t addr;
    logic     in_range;
    bit       seen [];
    passed = 1'b1;
    @(negedge clk);
    mem.fill_source(src_base, lines);
    @(posedge clk);
    #2;
    src_buf     = '{address: src_base, size: 32'(lines)};
    dst_buf     = '{address: dst_base, size: 32'(lines)};
    hc_dsm_base = DSM_ADDR;
    apply_reset();
    check_idle(name, 8);
    @(posedge clk);
    #2 hc_control = HC_CONTROL_START;
    @(posedge clk);
    #2 hc_control = '0;

    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: %s never raised done", name);
      timeouts++;
      passed = 1'b0;
      return;
    end
    cycles = 0;
    while (mem.log_addr.size() < lines + 1 && cycles < LOG_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (mem.log_addr.size() < lines + 1) begin
      $display("Timeout: %s saw only %0d of %0d writes", name, mem.log_addr.size(), lines + 1);
      timeouts++;
      passed = 1'b0;
      return;
    end

    check_value({name, " write count"}, lines + 1, mem.log_addr.size());
    seen = new[lines];
    for (int i = 0; i < lines; i++) begin
      addr     = mem.log_addr[i];
      in_range = (addr >= dst_base) && (addr < dst_base + cl_addr_t'(lines));
      check_value({name, " write address in buffer"}, 1, in_range);
      if (in_range) begin
        off = int'(addr - dst_base);
        check_value({name, " write address unique"}, 0, seen[off]);
        seen[off] = 1'b1;
        check_value({name, " line data"}, gray_line(mem.src_mem[src_base + cl_addr_t'(off)]),
                    mem.log_data[i]);
      end
    end
    check_value({name, " completion address"}, DSM_ADDR, mem.log_addr[lines]);
    check_value({name, " completion data"}, 1, mem.log_data[lines]);
    check_value({name, " responses before completion"}, lines, mem.log_rsps[lines]);
    check_value({name, " done level"}, 1, done);
  endtask

  task automatic report_and_finish();
    int sva_errors;
    sva_errors = DUT.u_requestor.u_sva.fail_cnt;
    $display("Errors: %0d checks, %0d assertions, %0d timeouts", errors, sva_errors, timeouts);
    if (errors == 0 && sva_errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    reset       = 1'b1;
    hc_control  = '0;
    hc_dsm_base = '0;
    src_buf     = '0;
    dst_buf     = '0;
    errors      = 0;
    timeouts    = 0;
    ok          = 1'b1;
    run_job("job_a", 40, 32'h0000_1000, 32'h0000_4000, ok);
    if (ok) begin
      run_job("job_b", 23, 32'h0000_2000, 32'h0000_6000, ok);  // Smaller job after a reset
    end
    report_and_finish();
  end

endmodule : gray_afu_tb

/* gray_mem_model.sv */
// Testbench memory that answers reads out of order, acknowledges writes and logs them
`timescale 1ns/100ps

module gray_mem_model import gray_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  rd_req_t rd_req,
  output rd_rsp_t rd_rsp,
  input  wr_req_t wr_req,
  output wr_rsp_t wr_rsp,
  output logic    rd_alm_full,
  output logic    wr_alm_full
);

  localparam int RD_HIGH_WATER = 7;  // Pending reads that raise almost-full, one more still lands

  logic [15:0] lfsr = 16'd26904;
  cl_data_t    src_mem   [cl_addr_t];
  cl_addr_t    pend_addr [$];
  int          pend_wait [$];
  int          ack_wait  [$];
  int          ack_total;
  cl_addr_t    log_addr  [$];  // Every write in arrival order
  cl_data_t    log_data  [$];
  int          log_rsps  [$];  // Write responses already sent when the write arrived

  // ##########################################################
  // Random source
  // ##########################################################

  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  task automatic fill_source(input cl_addr_t base, input int lines);
    cl_data_t value;
    for (int l = 0; l < lines; l++) begin
      for (int k = 0; k < 512; k++) begin
        value[k] = take_bit();
      end
      src_mem[base + cl_addr_t'(l)] = value;
    end
  endtask

  initial begin
    rd_rsp      = '0;
    wr_rsp      = '0;
    rd_alm_full = 1'b0;
    wr_alm_full = 1'b0;
  end

  // ##########################################################
  // Channel behavior
  // ##########################################################

  always @(posedge clk) begin
    rd_req_t  rd_seen;
    wr_req_t  wr_seen;
    logic     in_reset;
    int       pick;
    cl_data_t rd_data;
    rd_seen  = rd_req;  // Requests are taken as they stood at the edge
    wr_seen  = wr_req;
    in_reset = reset;
    #2;
    if (in_reset) begin
      pend_addr.delete();
      pend_wait.delete();
      ack_wait.delete();
      log_addr.delete();
      log_data.delete();
      log_rsps.delete();
      ack_total   = 0;
      rd_rsp      = '0;
      wr_rsp      = '0;
      rd_alm_full = 1'b0;
      wr_alm_full = 1'b0;
    end else begin
      foreach (pend_wait[i]) begin
        if (pend_wait[i] > 0) begin
          pend_wait[i]--;
        end
      end
      pick = -1;
      foreach (pend_wait[i]) begin
        if (pick < 0 && pend_wait[i] == 0) begin
          pick = i;  // Oldest ready read wins so short delays overtake long ones
        end
      end
      if (pick >= 0) begin
        rd_data = src_mem.exists(pend_addr[pick]) ? src_mem[pend_addr[pick]] : '0;
        rd_rsp  = '{valid: 1'b1, address: pend_addr[pick], data: rd_data};
        pend_addr.delete(pick);
        pend_wait.delete(pick);
      end else begin
        rd_rsp = '0;
      end
      if (rd_seen.valid) begin
        pend_addr.push_back(rd_seen.address);
        pend_wait.push_back(1 + int'(take_bits(3)));
      end
      rd_alm_full = (pend_addr.size() >= RD_HIGH_WATER) || (take_bits(2) == 32'd3);

      foreach (ack_wait[i]) begin
        ack_wait[i]--;
      end
      if (ack_wait.size() > 0 && ack_wait[0] <= 0) begin
        void'(ack_wait.pop_front());
        wr_rsp.valid = 1'b1;
      end else begin
        wr_rsp.valid = 1'b0;
      end
      if (wr_seen.valid) begin
        log_addr.push_back(wr_seen.address);
        log_data.push_back(wr_seen.data);
        log_rsps.push_back(ack_total);
        ack_wait.push_back(1 + int'(take_bits(2)));
      end
      if (wr_rsp.valid) begin
        ack_total++;
      end
      wr_alm_full = (take_bits(2) == 32'd3);
    end
  end

endmodule : gray_mem_model

/* gray_afu_sva.sv */
// Concurrent checks bound into the requestor for back-pressure, read credits and FIFO safety
`timescale 1ns/100ps

module gray_afu_sva import gray_pkg::*; #(
  parameter int FIFO_DEPTH      = 16,
  parameter int MAX_OUTSTANDING = 32
) (
  input logic                                 clk,
  input logic                                 reset,
  input rd_req_t                              rd_req,
  input wr_req_t                              wr_req,
  input logic                                 rd_alm_full,
  input logic                                 wr_alm_full,
  input logic                                 rsp_valid,
  input logic [$clog2(FIFO_DEPTH+1)-1:0]      fifo_count,
  input logic [$clog2(MAX_OUTSTANDING+1)-1:0] outstanding
);

  int fail_cnt = 0;  // Failed assertions so far

  rd_backpressure: assert property (@(posedge clk) disable iff (reset)
    rd_alm_full |=> !rd_req.valid)
    else begin
      fail_cnt++;
      $error("Read request issued after read almost-full was high");
    end

  wr_backpressure: assert property (@(posedge clk) disable iff (reset)
    wr_alm_full |=> !wr_req.valid)
    else begin
      fail_cnt++;
      $error("Write request issued after write almost-full was high");
    end

  outstanding_bound: assert property (@(posedge clk) disable iff (reset)
    32'(outstanding) <= 32'(MAX_OUTSTANDING))
    else begin
      fail_cnt++;
      $error("Outstanding reads exceed the limit");
    end

  // A response reaches the FIFO two cycles later through the converter
  fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    rsp_valid |-> ##2 (32'(fifo_count) < 32'(FIFO_DEPTH)))
    else begin
      fail_cnt++;
      $error("Converted line enqueued while the FIFO was full");
    end

endmodule : gray_afu_sva

bind gray_requestor gray_afu_sva #(
  .FIFO_DEPTH      (FIFO_DEPTH),
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) u_sva (
  .clk         (clk),
  .reset       (reset),
  .rd_req      (rd_req),
  .wr_req      (wr_req),
  .rd_alm_full (rd_alm_full),
  .wr_alm_full (wr_alm_full),
  .rsp_valid   (rsp_valid),
  .fifo_count  (fifo_count),
  .outstanding (outstanding)
);

/* gray_afu.sv */
// Grayscale accelerator top level, joining requestor, converter and line FIFO
`timescale 1ns/100ps

module gray_afu import gray_pkg::*; #(
  parameter int FIFO_DEPTH      = 16,
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] hc_control,
  input  cl_addr_t    hc_dsm_base,
  input  buf_desc_t   src_buf,
  input  buf_desc_t   dst_buf,
  output rd_req_t     rd_req,
  input  rd_rsp_t     rd_rsp,
  output wr_req_t     wr_req,
  input  wr_rsp_t     wr_rsp,
  input  logic        rd_alm_full,
  input  logic        wr_alm_full,
  output logic        done
);

  line_t                           rsp_line;
  logic                            rsp_valid;
  line_t                           conv_line;
  logic                            conv_valid;
  line_t                           fifo_line;
  logic                            not_empty;
  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
  logic                            deq;

  gray_requestor #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_requestor (
    .clk         (clk),
    .reset       (reset),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .src_buf     (src_buf),
    .dst_buf     (dst_buf),
    .rd_rsp      (rd_rsp),
    .wr_rsp      (wr_rsp),
    .rd_alm_full (rd_alm_full),
    .wr_alm_full (wr_alm_full),
    .fifo_line   (fifo_line),
    .not_empty   (not_empty),
    .fifo_count  (fifo_count),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .rsp_line    (rsp_line),
    .rsp_valid   (rsp_valid),
    .deq         (deq),
    .done        (done)
  );

  gray_pixel_conv u_pixel_conv (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (rsp_valid),
    .in_line   (rsp_line),
    .out_valid (conv_valid),
    .out_line  (conv_line)
  );

  gray_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .enq       (conv_valid),
    .enq_line  (conv_line),
    .deq       (deq),
    .deq_line  (fifo_line),
    .not_full  (),
    .not_empty (not_empty),
    .count     (fifo_count)
  );

endmodule : gray_afu

/* gray_requestor.sv */
// Read and write request engine that streams source lines in and converted lines out
`timescale 1ns/100ps

module gray_requestor import gray_pkg::*; #(
  parameter int FIFO_DEPTH      = 16,
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [31:0]                     hc_control,
  input  cl_addr_t                        hc_dsm_base,
  input  buf_desc_t                       src_buf,
  input  buf_desc_t                       dst_buf,
  input  rd_rsp_t                         rd_rsp,
  input  wr_rsp_t                         wr_rsp,
  input  logic                            rd_alm_full,
  input  logic                            wr_alm_full,
  input  line_t                           fifo_line,
  input  logic                            not_empty,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
  output rd_req_t                         rd_req,
  output wr_req_t                         wr_req,
  output line_t                           rsp_line,
  output logic                            rsp_valid,
  output logic                            deq,
  output logic                            done
);

  localparam int OUT_W      = $clog2(MAX_OUTSTANDING + 1);
  localparam int PIPE_SLOTS = 3;  // Response register plus two converter stages

  // ##########################################################
  // Read side
  // ##########################################################

  rd_state_t         rd_state;
  rd_state_t         rd_next_state;
  logic [31:0]       rd_offset;
  logic [OUT_W-1:0]  outstanding;
  logic [31:0]       rd_credit;
  logic              rd_issue;
  logic              rd_valid_q;
  cl_addr_t          rd_addr_q;

  // Lines owed to the FIFO after this issue, counting every pipeline slot as taken
  assign rd_credit = 32'(outstanding) + 32'(fifo_count) + 32'(PIPE_SLOTS) + 32'd1;

  assign rd_issue = (rd_state == S_RD_FETCH) && !rd_alm_full &&
                    (rd_offset < src_buf.size) &&
                    (32'(outstanding) < 32'(MAX_OUTSTANDING)) &&
                    (rd_credit <= 32'(FIFO_DEPTH));

  always_comb begin
    rd_next_state = rd_state;
    case (rd_state)
      S_RD_IDLE: begin
        if (hc_control == HC_CONTROL_START) begin
          rd_next_state = S_RD_FETCH;
        end
      end
      S_RD_FETCH: begin
        if (rd_offset == src_buf.size) begin
          rd_next_state = S_RD_FINISH;
        end
      end
      default: rd_next_state = rd_state;  // Finish holds until the next reset
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state    <= S_RD_IDLE;
      rd_offset   <= '0;
      rd_valid_q  <= 1'b0;
      outstanding <= '0;
    end else begin
      rd_state   <= rd_next_state;
      rd_valid_q <= rd_issue;
      if (rd_issue) begin
        rd_offset <= rd_offset + 1'b1;
      end
      case ({rd_issue, rd_rsp.valid})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      rd_addr_q <= src_buf.address + rd_offset;
    end
  end

  assign rd_req = '{valid: rd_valid_q, address: rd_addr_q};

  // Returned lines may arrive out of order, so the tag becomes the buffer offset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_rsp.valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_line.address <= rd_rsp.address - src_buf.address;
    rsp_line.data    <= rd_rsp.data;
  end

  // ##########################################################
  // Write side
  // ##########################################################

  wr_state_t   wr_state;
  wr_state_t   wr_next_state;
  logic [31:0] wr_cnt;
  logic [31:0] wr_rsp_cnt;
  logic        wr_issue;
  logic        dsm_issue;
  logic        wr_valid_q;
  cl_addr_t    wr_addr_q;
  cl_data_t    wr_data_q;

  assign wr_issue  = (wr_state == S_WR_DATA) && !wr_alm_full && not_empty &&
                     (wr_cnt < dst_buf.size);
  assign dsm_issue = (wr_state == S_WR_FINISH_1) && !wr_alm_full &&
                     (wr_rsp_cnt == dst_buf.size);
  assign deq       = wr_issue;  // Head leaves the FIFO on the edge that registers its write
  assign done      = (wr_state == S_WR_FINISH_2);

  always_comb begin
    wr_next_state = wr_state;
    case (wr_state)
      S_WR_IDLE: begin
        if (hc_control == HC_CONTROL_START) begin
          wr_next_state = S_WR_DATA;
        end
      end
      S_WR_DATA: begin
        if (wr_cnt == dst_buf.size) begin
          wr_next_state = S_WR_FINISH_1;
        end
      end
      S_WR_FINISH_1: begin
        if (dsm_issue) begin
          wr_next_state = S_WR_FINISH_2;
        end
      end
      default: wr_next_state = wr_state;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state   <= S_WR_IDLE;
      wr_cnt     <= '0;
      wr_rsp_cnt <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_state   <= wr_next_state;
      wr_valid_q <= wr_issue || dsm_issue;
      if (wr_issue) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (wr_rsp.valid) begin
        wr_rsp_cnt <= wr_rsp_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_issue) begin
      wr_addr_q <= dst_buf.address + fifo_line.address;
      wr_data_q <= fifo_line.data;
    end else if (dsm_issue) begin
      wr_addr_q <= hc_dsm_base;
      wr_data_q <= cl_data_t'(1);  // Completion flag seen by the host
    end
  end

  assign wr_req = '{valid: wr_valid_q, address: wr_addr_q, data: wr_data_q};

endmodule : gray_requestor

/* gray_pixel_conv.sv */
// Two-stage RGBA to grayscale converter for one cache line, tag carried with the data
`timescale 1ns/100ps

module gray_pixel_conv import gray_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  line_t in_line,
  output logic  out_valid,
  output line_t out_line
);

  localparam int PIXELS = 16;

  // Weighted channels of one pixel between the two stages
  typedef struct packed {
    logic [15:0] r;
    logic [15:0] g;
    logic [15:0] b;
    logic [7:0]  a;
  } pix_prod_t;

  pix_prod_t   s1_prod [PIXELS];
  logic        s1_valid;
  cl_addr_t    s1_addr;
  logic [15:0] sum     [PIXELS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // ##########################################################
  // Stage 1, per-channel products
  // ##########################################################

  always_ff @(posedge clk) begin
    s1_addr <= in_line.address;
    for (int i = 0; i < PIXELS; i++) begin
      s1_prod[i].r <= 16'(in_line.data[32*i +: 8]) * 16'd77;
      s1_prod[i].g <= 16'(in_line.data[32*i+8 +: 8]) * 16'd150;
      s1_prod[i].b <= 16'(in_line.data[32*i+16 +: 8]) * 16'd29;
      s1_prod[i].a <= in_line.data[32*i+24 +: 8];
    end
  end

  // ##########################################################
  // Stage 2, sum and scale
  // ##########################################################

  // Weights add up to 256 so the sum never exceeds 16 bits
  always_comb begin
    for (int i = 0; i < PIXELS; i++) begin
      sum[i] = s1_prod[i].r + s1_prod[i].g + s1_prod[i].b;
    end
  end

  always_ff @(posedge clk) begin
    out_line.address <= s1_addr;
    for (int i = 0; i < PIXELS; i++) begin
      out_line.data[32*i +: 32] <= {s1_prod[i].a, sum[i][15:8], sum[i][15:8], sum[i][15:8]};
    end
  end

endmodule : gray_pixel_conv

/* gray_fifo.sv */
// First-word-fall-through FIFO that buffers converted lines ahead of the write channel
`timescale 1ns/100ps

module gray_fifo import gray_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enq,
  input  line_t                        enq_line,
  input  logic                         deq,
  output line_t                        deq_line,
  output logic                         not_full,
  output logic                         not_empty,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  line_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_enq;
  logic             do_deq;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Depth need not be a power of two
  endfunction

  assign not_full  = (count < CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign do_enq    = enq && not_full;
  assign do_deq    = deq && not_empty;
  assign deq_line  = mem[rd_ptr];  // Head is visible while not_empty is high

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_line;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Simultaneous enqueue and dequeue keeps the level
      endcase
    end
  end

endmodule : gray_fifo

/* gray_pkg.sv */
// Shared types for the grayscale accelerator, imported by every design module
package gray_pkg;

  // ##########################################################
  // Memory channel types
  // ##########################################################

  typedef logic [31:0]  cl_addr_t;  // Cache-line address
  typedef logic [511:0] cl_data_t;  // One cache line of 16 RGBA pixels

  typedef struct packed {
    cl_addr_t    address;  // First line of the buffer
    logic [31:0] size;     // Number of lines
  } buf_desc_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t address;
  } rd_req_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t address;  // Echo of the request address, used as the line tag
    cl_data_t data;
  } rd_rsp_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t address;
    cl_data_t data;
  } wr_req_t;

  typedef struct packed {
    logic valid;
  } wr_rsp_t;

  // Line as it moves through the converter and the FIFO
  typedef struct packed {
    cl_addr_t address;  // Offset from the start of the buffer
    cl_data_t data;
  } line_t;

  // ##########################################################
  // Control
  // ##########################################################

  typedef enum logic [1:0] {
    S_RD_IDLE,
    S_RD_FETCH,
    S_RD_FINISH
  } rd_state_t;

  typedef enum logic [1:0] {
    S_WR_IDLE,
    S_WR_DATA,
    S_WR_FINISH_1,
    S_WR_FINISH_2
  } wr_state_t;

  localparam logic [31:0] HC_CONTROL_START = 32'h0000_0001;  // Host word that starts a job

endpackage : gray_pkg
